// File: decode_execute.f
source/or1k_isa_pkg.sv
source/decode_pipe_pkg.sv
source/hazard_detect.sv
source/branch_resolve.sv
source/decode_execute_regs.sv
source/decode_execute_top.sv
verif/tb_clock_gen.sv
verif/decode_execute_sva.sv
verif/tb_decode_execute.sv

// File: run_sim.sh
#!/bin/sh
# build and run the decode/execute testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --top-module tb_decode_execute \
   -f decode_execute.f \
   -o sim_decode_execute
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/sim_decode_execute > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "SOME TESTS FAILED" sim.log; then
   exit 1
fi
exit 0

// File: source/branch_resolve.sv
// decode-stage branch decision, target select, alignment check, link and mispredict pc
`timescale 1ns/10ps

module branch_resolve #(
   parameter bit DELAY_SLOT = 1'b1
) (
   input  or1k_isa_pkg::operand_t      pc_decode_i,
   input  or1k_isa_pkg::operand_t      decode_rfb_i,
   input  or1k_isa_pkg::operand_t      execute_rfb_i,
   input  or1k_isa_pkg::imm16_t        decode_imm16_i,
   input  or1k_isa_pkg::immjbr_upper_t decode_immjbr_upper_i,
   input  or1k_isa_pkg::opcode_t       decode_opc_insn_i,
   input  logic                        decode_op_jbr_i,
   input  logic                        decode_op_jr_i,
   input  logic                        decode_op_bf_i,
   input  logic                        decode_op_bnf_i,
   input  logic                        predicted_flag_i,
   input  logic                        pipeline_flush_i,
   input  logic                        decode_bubble_i,
   input  logic                        jr_clear_i,
   input  logic                        execute_bubble_i,
   input  logic                        execute_op_jr_i,
   output logic                        decode_branch_o,
   output or1k_isa_pkg::operand_t      decode_branch_target_o,
   output or1k_isa_pkg::operand_t      next_pc_o,
   output or1k_isa_pkg::operand_t      mispredict_target_o,
   output logic                        except_ibus_align_o
);
   import or1k_isa_pkg::*;
   import decode_pipe_pkg::*;

   // word offset made of upper immediate, imm16 and two zero bits
   localparam int OFFSET_WIDTH = IMMJBR_UPPER_WIDTH + IMM16_WIDTH + 2;

   logic     branch_to_imm;
   logic     branch_to_reg;
   operand_t imm_target;
   operand_t reg_target;

   // l.j/l.jal always, l.bf/l.bnf when the predicted flag agrees
   assign branch_to_imm = decode_op_jbr_i &
                          ((decode_opc_insn_i[2:1] == 2'b00) |
                           (decode_opc_insn_i[2] == predicted_flag_i));

   assign imm_target = pc_decode_i +
                       {{(OPERAND_WIDTH-OFFSET_WIDTH){decode_immjbr_upper_i[IMMJBR_UPPER_WIDTH-1]}},
                        decode_immjbr_upper_i, decode_imm16_i, 2'b00};

   assign branch_to_reg = decode_op_jr_i & jr_clear_i;

   // after a bubble the target register value is only valid from execute
   assign reg_target = (execute_bubble_i | execute_op_jr_i) ? execute_rfb_i : decode_rfb_i;

   assign decode_branch_o = (branch_to_imm | branch_to_reg) &
                            ~pipeline_flush_i & ~decode_bubble_i;

   assign decode_branch_target_o = branch_to_imm ? imm_target : reg_target;

   assign except_ibus_align_o = decode_branch_o & (|decode_branch_target_o[1:0]);

   // skip the delay slot when it is present
   assign next_pc_o = pc_decode_i +
                      (DELAY_SLOT ? operand_t'(2 * PC_STEP) : operand_t'(PC_STEP));

   // the path not taken by the prediction
   assign mispredict_target_o = ((decode_op_bf_i & ~predicted_flag_i) |
                                 (decode_op_bnf_i & predicted_flag_i)) ?
                                imm_target : next_pc_o;

endmodule

// File: source/decode_execute_regs.sv
// decode to execute pipeline register with flush, bubble and rfe rules
`timescale 1ns/10ps

module decode_execute_regs (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        padv_i,
   input  logic                        pipeline_flush_i,
   input  logic                        decode_bubble_i,
   input  decode_pipe_pkg::op_flags_t  decode_op_flags_i,
   input  logic                        decode_op_rfe_i,
   input  logic                        decode_rf_wb_i,
   input  logic                        decode_op_brcond_i,
   input  logic                        predicted_flag_i,
   input  or1k_isa_pkg::opcode_t       decode_opc_insn_i,
   input  or1k_isa_pkg::rf_adr_t       decode_rfd_adr_i,
   input  or1k_isa_pkg::imm16_t        decode_imm16_i,
   input  or1k_isa_pkg::immjbr_upper_t decode_immjbr_upper_i,
   input  or1k_isa_pkg::operand_t      pc_decode_i,
   input  or1k_isa_pkg::operand_t      next_pc_i,
   input  or1k_isa_pkg::operand_t      mispredict_target_i,
   input  logic                        decode_except_illegal_i,
   input  logic                        decode_except_syscall_i,
   input  logic                        except_ibus_align_i,
   output decode_pipe_pkg::op_flags_t  execute_op_flags_o,
   output logic                        execute_op_rfe_o,
   output logic                        execute_rf_wb_o,
   output or1k_isa_pkg::opcode_t       execute_opc_insn_o,
   output or1k_isa_pkg::rf_adr_t       execute_rfd_adr_o,
   output or1k_isa_pkg::imm16_t        execute_imm16_o,
   output or1k_isa_pkg::immjbr_upper_t execute_immjbr_upper_o,
   output or1k_isa_pkg::operand_t      pc_execute_o,
   output or1k_isa_pkg::operand_t      execute_jal_result_o,
   output or1k_isa_pkg::operand_t      execute_mispredict_target_o,
   output logic                        execute_predicted_flag_o,
   output logic                        execute_except_illegal_o,
   output logic                        execute_except_syscall_o,
   output logic                        execute_except_ibus_align_o,
   output logic                        execute_bubble_o,
   output logic                        decode_valid_o
);
   import or1k_isa_pkg::*;

   // control fields, cleared by flush, emptied by a bubble
   always_ff @(posedge clk) begin
      if (rst || pipeline_flush_i) begin
         execute_op_flags_o <= '0;
         execute_rf_wb_o <= 1'b0;
         execute_opc_insn_o <= OPCODE_NOP;
         execute_op_rfe_o <= 1'b0;
         execute_bubble_o <= 1'b0;
      end else if (padv_i) begin
         execute_bubble_o <= decode_bubble_i;
         // rfe keeps moving through bubbles until it reaches ctrl
         execute_op_rfe_o <= decode_op_rfe_i;
         if (decode_bubble_i) begin
            execute_op_flags_o <= '0;
            execute_rf_wb_o <= 1'b0;
            execute_opc_insn_o <= OPCODE_NOP;
         end else begin
            execute_op_flags_o <= decode_op_flags_i;
            execute_rf_wb_o <= decode_rf_wb_i;
            execute_opc_insn_o <= decode_opc_insn_i;
         end
      end
   end

   // decode exceptions
   always_ff @(posedge clk) begin
      if (rst) begin
         execute_except_illegal_o <= 1'b0;
         execute_except_syscall_o <= 1'b0;
         execute_except_ibus_align_o <= 1'b0;
      end else if (padv_i) begin
         execute_except_illegal_o <= decode_except_illegal_i;
         execute_except_syscall_o <= decode_except_syscall_i;
         execute_except_ibus_align_o <= except_ibus_align_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         decode_valid_o <= 1'b0;
      end else begin
         decode_valid_o <= padv_i;
      end
   end

   // payload fields
   always_ff @(posedge clk) begin
      if (padv_i) begin
         execute_rfd_adr_o <= decode_rfd_adr_i;
         execute_imm16_o <= decode_imm16_i;
         execute_immjbr_upper_o <= decode_immjbr_upper_i;
         pc_execute_o <= pc_decode_i;
         // link value for jal
         execute_jal_result_o <= next_pc_i;
      end
   end

   // prediction info, only meaningful for conditional branches
   always_ff @(posedge clk) begin
      if (padv_i && decode_op_brcond_i) begin
         execute_mispredict_target_o <= mispredict_target_i;
         execute_predicted_flag_o <= predicted_flag_i;
      end
   end

endmodule

// File: source/decode_execute_top.sv
// decode to execute boundary top level with hazard, branch and stage register units
`timescale 1ns/10ps

module decode_execute_top #(
   parameter bit DELAY_SLOT = 1'b1
) (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        padv_i,
   input  logic                        pipeline_flush_i,
   input  decode_pipe_pkg::op_flags_t  decode_op_flags_i,
   input  logic                        decode_op_rfe_i,
   input  logic                        decode_rf_wb_i,
   input  or1k_isa_pkg::opcode_t       decode_opc_insn_i,
   input  or1k_isa_pkg::rf_adr_t       decode_rfa_adr_i,
   input  or1k_isa_pkg::rf_adr_t       decode_rfb_adr_i,
   input  or1k_isa_pkg::rf_adr_t       decode_rfd_adr_i,
   input  or1k_isa_pkg::imm16_t        decode_imm16_i,
   input  or1k_isa_pkg::immjbr_upper_t decode_immjbr_upper_i,
   input  or1k_isa_pkg::operand_t      pc_decode_i,
   input  logic                        decode_op_bf_i,
   input  logic                        decode_op_bnf_i,
   input  logic                        predicted_flag_i,
   input  or1k_isa_pkg::operand_t      decode_rfb_i,
   input  or1k_isa_pkg::operand_t      execute_rfb_i,
   input  logic                        ctrl_op_lsu_load_i,
   input  logic                        ctrl_op_mfspr_i,
   input  or1k_isa_pkg::rf_adr_t       ctrl_rfd_adr_i,
   input  logic                        decode_except_illegal_i,
   input  logic                        decode_except_syscall_i,
   output decode_pipe_pkg::op_flags_t  execute_op_flags_o,
   output logic                        execute_op_rfe_o,
   output logic                        execute_rf_wb_o,
   output or1k_isa_pkg::opcode_t       execute_opc_insn_o,
   output or1k_isa_pkg::rf_adr_t       execute_rfd_adr_o,
   output or1k_isa_pkg::imm16_t        execute_imm16_o,
   output or1k_isa_pkg::immjbr_upper_t execute_immjbr_upper_o,
   output or1k_isa_pkg::operand_t      pc_execute_o,
   output or1k_isa_pkg::operand_t      execute_jal_result_o,
   output or1k_isa_pkg::operand_t      execute_mispredict_target_o,
   output logic                        execute_predicted_flag_o,
   output logic                        execute_except_illegal_o,
   output logic                        execute_except_syscall_o,
   output logic                        execute_except_ibus_align_o,
   output logic                        execute_bubble_o,
   output logic                        decode_valid_o,
   output logic                        decode_bubble_o,
   output logic                        decode_branch_o,
   output or1k_isa_pkg::operand_t      decode_branch_target_o
);
   import or1k_isa_pkg::*;
   import decode_pipe_pkg::*;

   logic     jr_clear;
   logic     except_ibus_align;
   operand_t next_pc;
   operand_t mispredict_target;

   hazard_detect hazard_detect_inst (
      .padv_i             (padv_i),
      .decode_op_jr_i     (decode_op_flags_i[OPF_JR]),
      .decode_op_rfe_i    (decode_op_rfe_i),
      .decode_rfa_adr_i   (decode_rfa_adr_i),
      .decode_rfb_adr_i   (decode_rfb_adr_i),
      .execute_rfd_adr_i  (execute_rfd_adr_o),
      .ctrl_rfd_adr_i     (ctrl_rfd_adr_i),
      .execute_op_flags_i (execute_op_flags_o),
      .ctrl_op_lsu_load_i (ctrl_op_lsu_load_i),
      .ctrl_op_mfspr_i    (ctrl_op_mfspr_i),
      .decode_bubble_o    (decode_bubble_o),
      .jr_clear_o         (jr_clear)
   );

   branch_resolve #(
      .DELAY_SLOT (DELAY_SLOT)
   ) branch_resolve_inst (
      .pc_decode_i            (pc_decode_i),
      .decode_rfb_i           (decode_rfb_i),
      .execute_rfb_i          (execute_rfb_i),
      .decode_imm16_i         (decode_imm16_i),
      .decode_immjbr_upper_i  (decode_immjbr_upper_i),
      .decode_opc_insn_i      (decode_opc_insn_i),
      .decode_op_jbr_i        (decode_op_flags_i[OPF_JBR]),
      .decode_op_jr_i         (decode_op_flags_i[OPF_JR]),
      .decode_op_bf_i         (decode_op_bf_i),
      .decode_op_bnf_i        (decode_op_bnf_i),
      .predicted_flag_i       (predicted_flag_i),
      .pipeline_flush_i       (pipeline_flush_i),
      .decode_bubble_i        (decode_bubble_o),
      .jr_clear_i             (jr_clear),
      .execute_bubble_i       (execute_bubble_o),
      .execute_op_jr_i        (execute_op_flags_o[OPF_JR]),
      .decode_branch_o        (decode_branch_o),
      .decode_branch_target_o (decode_branch_target_o),
      .next_pc_o              (next_pc),
      .mispredict_target_o    (mispredict_target),
      .except_ibus_align_o    (except_ibus_align)
   );

   decode_execute_regs decode_execute_regs_inst (
      .clk                         (clk),
      .rst                         (rst),
      .padv_i                      (padv_i),
      .pipeline_flush_i            (pipeline_flush_i),
      .decode_bubble_i             (decode_bubble_o),
      .decode_op_flags_i           (decode_op_flags_i),
      .decode_op_rfe_i             (decode_op_rfe_i),
      .decode_rf_wb_i              (decode_rf_wb_i),
      .decode_op_brcond_i          (decode_op_flags_i[OPF_BRCOND]),
      .predicted_flag_i            (predicted_flag_i),
      .decode_opc_insn_i           (decode_opc_insn_i),
      .decode_rfd_adr_i            (decode_rfd_adr_i),
      .decode_imm16_i              (decode_imm16_i),
      .decode_immjbr_upper_i       (decode_immjbr_upper_i),
      .pc_decode_i                 (pc_decode_i),
      .next_pc_i                   (next_pc),
      .mispredict_target_i         (mispredict_target),
      .decode_except_illegal_i     (decode_except_illegal_i),
      .decode_except_syscall_i     (decode_except_syscall_i),
      .except_ibus_align_i         (except_ibus_align),
      .execute_op_flags_o          (execute_op_flags_o),
      .execute_op_rfe_o            (execute_op_rfe_o),
      .execute_rf_wb_o             (execute_rf_wb_o),
      .execute_opc_insn_o          (execute_opc_insn_o),
      .execute_rfd_adr_o           (execute_rfd_adr_o),
      .execute_imm16_o             (execute_imm16_o),
      .execute_immjbr_upper_o      (execute_immjbr_upper_o),
      .pc_execute_o                (pc_execute_o),
      .execute_jal_result_o        (execute_jal_result_o),
      .execute_mispredict_target_o (execute_mispredict_target_o),
      .execute_predicted_flag_o    (execute_predicted_flag_o),
      .execute_except_illegal_o    (execute_except_illegal_o),
      .execute_except_syscall_o    (execute_except_syscall_o),
      .execute_except_ibus_align_o (execute_except_ibus_align_o),
      .execute_bubble_o            (execute_bubble_o),
      .decode_valid_o              (decode_valid_o)
   );

endmodule

// File: source/decode_pipe_pkg.sv
// operation flag vector type, flag bit positions, instruction step
package decode_pipe_pkg;

   parameter int OPF_WIDTH = 14;

   // one bit per operation class decoded from the instruction
   typedef logic [OPF_WIDTH-1:0] op_flags_t;

   // alu class
   parameter int OPF_ALU = 0;
   parameter int OPF_ADD = 1;
   parameter int OPF_SHIFT = 2;
   parameter int OPF_MOVHI = 3;

   // special purpose register access
   parameter int OPF_MFSPR = 4;
   parameter int OPF_MTSPR = 5;

   // load/store unit
   parameter int OPF_LOAD = 6;
   parameter int OPF_STORE = 7;

   // compare, sets the flag in ctrl
   parameter int OPF_SETFLAG = 8;

   // jumps and branches
   parameter int OPF_JBR = 9;
   parameter int OPF_JR = 10;
   parameter int OPF_JAL = 11;
   parameter int OPF_BRCOND = 12;
   parameter int OPF_BRANCH = 13;

   // instruction size in bytes
   parameter int PC_STEP = 4;

endpackage

// File: source/hazard_detect.sv
// load-use and jump-register hazard detection for the decode stage
`timescale 1ns/10ps

module hazard_detect (
   input  logic                       padv_i,
   input  logic                       decode_op_jr_i,
   input  logic                       decode_op_rfe_i,
   input  or1k_isa_pkg::rf_adr_t      decode_rfa_adr_i,
   input  or1k_isa_pkg::rf_adr_t      decode_rfb_adr_i,
   input  or1k_isa_pkg::rf_adr_t      execute_rfd_adr_i,
   input  or1k_isa_pkg::rf_adr_t      ctrl_rfd_adr_i,
   input  decode_pipe_pkg::op_flags_t execute_op_flags_i,
   input  logic                       ctrl_op_lsu_load_i,
   input  logic                       ctrl_op_mfspr_i,
   output logic                       decode_bubble_o,
   output logic                       jr_clear_o
);
   import decode_pipe_pkg::*;

   logic ctrl_interlock;
   logic execute_late_result;
   logic execute_operand_hit;
   logic jr_hazard;

   // ctrl still has to produce the jump register operand
   assign ctrl_interlock = (ctrl_op_lsu_load_i | ctrl_op_mfspr_i) &
                           (decode_rfb_adr_i == ctrl_rfd_adr_i);

   assign jr_clear_o = ~ctrl_interlock;

   // load and mfspr results only appear in ctrl, too late for bypass
   assign execute_late_result = execute_op_flags_i[OPF_LOAD] |
                                execute_op_flags_i[OPF_MFSPR];

   assign execute_operand_hit = execute_late_result &
                                ((decode_rfa_adr_i == execute_rfd_adr_i) |
                                 (decode_rfb_adr_i == execute_rfd_adr_i));

   // jr target register written by execute or pending in ctrl
   assign jr_hazard = decode_op_jr_i &
                      (ctrl_interlock | (decode_rfb_adr_i == execute_rfd_adr_i));

   // rfe stalls fetch while it travels up to ctrl
   assign decode_bubble_o = padv_i &
                            (execute_operand_hit | jr_hazard | decode_op_rfe_i);

endmodule

// File: source/or1k_isa_pkg.sv
// instruction-set widths, operand and field types, nop opcode
package or1k_isa_pkg;

   // data path and register file
   parameter int OPERAND_WIDTH = 32;
   parameter int RF_ADR_WIDTH = 5;

   // instruction word fields
   parameter int OPCODE_WIDTH = 6;
   parameter int IMM16_WIDTH = 16;
   parameter int IMMJBR_UPPER_WIDTH = 10;

   // data word or address
   typedef logic [OPERAND_WIDTH-1:0] operand_t;

   // general purpose register index
   typedef logic [RF_ADR_WIDTH-1:0] rf_adr_t;

   // major opcode, instruction bits 31:26
   typedef logic [OPCODE_WIDTH-1:0] opcode_t;

   // low immediate, instruction bits 15:0
   typedef logic [IMM16_WIDTH-1:0] imm16_t;

   // upper jump/branch immediate, instruction bits 25:16
   typedef logic [IMMJBR_UPPER_WIDTH-1:0] immjbr_upper_t;

   // l.nop major opcode, also marks an empty slot in the pipeline
   parameter opcode_t OPCODE_NOP = 6'h05;

endpackage

// File: verif/decode_execute_sva.sv
// bound assertions for the flush, bubble and decode valid rules of the stage register
`timescale 1ns/10ps

module decode_execute_sva (
   input logic                       clk,
   input logic                       rst,
   input logic                       padv_i,
   input logic                       pipeline_flush_i,
   input logic                       decode_bubble_i,
   input decode_pipe_pkg::op_flags_t execute_op_flags_o,
   input logic                       execute_rf_wb_o,
   input or1k_isa_pkg::opcode_t      execute_opc_insn_o,
   input logic                       execute_bubble_o,
   input logic                       decode_valid_o
);
   import or1k_isa_pkg::*;

   // flush empties the control fields whatever advance does
   flush_clears_stage: assert property (@(posedge clk) disable iff (rst)
      pipeline_flush_i |=> (execute_op_flags_o == '0) && !execute_bubble_o)
      else $error("flush did not clear execute flags and bubble");

   // an advanced bubble leaves an empty slot
   bubble_inserts_nop: assert property (@(posedge clk) disable iff (rst)
      (padv_i && decode_bubble_i && !pipeline_flush_i) |=>
         !execute_rf_wb_o && (execute_opc_insn_o == OPCODE_NOP))
      else $error("bubble did not produce an empty execute slot");

   decode_valid_follows_advance: assert property (@(posedge clk)
      !rst |=> (decode_valid_o == $past(padv_i)))
      else $error("decode valid is not advance delayed by one cycle");

endmodule

bind decode_execute_regs decode_execute_sva decode_execute_sva_inst (.*);

// File: verif/tb_clock_gen.sv
// free-running clock source for the testbench
`timescale 1ns/10ps

module tb_clock_gen #(
   parameter int PERIOD_NS = 40
) (
   output logic clk_o
);

   initial begin
      clk_o = 1'b0;
   end

   // half period high, half period low
   always begin
      #(PERIOD_NS / 2);
      clk_o = ~clk_o;
   end

endmodule

// File: verif/tb_decode_execute.sv
// testbench top with lfsr stimulus, reference model, compare tasks and timeout
`timescale 1ns/10ps

module tb_decode_execute;
   import or1k_isa_pkg::*;
   import decode_pipe_pkg::*;

   localparam int RESET_CYCLES = 8;
   localparam int DIRECTED_CYCLES = 8;
   localparam int RANDOM_CYCLES = 2000;
   localparam int TIMEOUT_CYCLES = (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES) * 5 / 4;

   logic clk;
   logic rst;

   // dut inputs
   logic padv, flush, rfe, rf_wb, bf, bnf, pred, c_load, c_mfspr, ill, sys;
   op_flags_t flags;
   opcode_t opc;
   rf_adr_t rfa, rfb, rfd, c_rfd;
   imm16_t imm16;
   immjbr_upper_t upper;
   operand_t pc, dec_rfb, ex_rfb;

   // dut outputs
   op_flags_t x_flags;
   logic x_rfe, x_rf_wb, x_pf, x_ill, x_sys, x_align, x_bubble, x_valid;
   opcode_t x_opc;
   rf_adr_t x_rfd;
   imm16_t x_imm16;
   immjbr_upper_t x_upper;
   operand_t x_pc, x_jal, x_mp;
   logic d_bubble, d_branch;
   operand_t d_target;

   // model of the execute stage
   op_flags_t m_flags;
   logic m_rfe, m_rf_wb, m_pf, m_ill, m_sys, m_align, m_bubble, m_valid;
   opcode_t m_opc;
   rf_adr_t m_rfd;
   imm16_t m_imm16;
   immjbr_upper_t m_upper;
   operand_t m_pc, m_jal, m_mp;
   logic payload_known, mp_known;

   logic [15:0] lfsr_state = 16'd52695;
   int error_count = 0;
   int check_count = 0;
   int cycle_count = 0;

   tb_clock_gen #(.PERIOD_NS(40)) clock_gen_inst (.clk_o(clk));

   decode_execute_top #(.DELAY_SLOT(1'b1)) decode_execute_top_inst (
      .clk(clk), .rst(rst), .padv_i(padv), .pipeline_flush_i(flush),
      .decode_op_flags_i(flags), .decode_op_rfe_i(rfe), .decode_rf_wb_i(rf_wb),
      .decode_opc_insn_i(opc), .decode_rfa_adr_i(rfa), .decode_rfb_adr_i(rfb),
      .decode_rfd_adr_i(rfd), .decode_imm16_i(imm16), .decode_immjbr_upper_i(upper),
      .pc_decode_i(pc), .decode_op_bf_i(bf), .decode_op_bnf_i(bnf),
      .predicted_flag_i(pred), .decode_rfb_i(dec_rfb), .execute_rfb_i(ex_rfb),
      .ctrl_op_lsu_load_i(c_load), .ctrl_op_mfspr_i(c_mfspr), .ctrl_rfd_adr_i(c_rfd),
      .decode_except_illegal_i(ill), .decode_except_syscall_i(sys),
      .execute_op_flags_o(x_flags), .execute_op_rfe_o(x_rfe), .execute_rf_wb_o(x_rf_wb),
      .execute_opc_insn_o(x_opc), .execute_rfd_adr_o(x_rfd), .execute_imm16_o(x_imm16),
      .execute_immjbr_upper_o(x_upper), .pc_execute_o(x_pc),
      .execute_jal_result_o(x_jal), .execute_mispredict_target_o(x_mp),
      .execute_predicted_flag_o(x_pf), .execute_except_illegal_o(x_ill),
      .execute_except_syscall_o(x_sys), .execute_except_ibus_align_o(x_align),
      .execute_bubble_o(x_bubble), .decode_valid_o(x_valid),
      .decode_bubble_o(d_bubble), .decode_branch_o(d_branch),
      .decode_branch_target_o(d_target)
   );

   // galois lfsr stepped once per bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] value;
      value = '0;
      for (int i = 0; i < n; i++) begin
         value = {value[30:0], lfsr_state[0]};
         lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
      end
      return value;
   endfunction

   task automatic count_result(input bit ok);
      check_count++;
      if (!ok) begin
         error_count++;
      end
   endtask

   task automatic check_flags(input string name, input op_flags_t exp, input op_flags_t act);
      count_result(exp === act);
      if (exp !== act) begin
         $display("MISMATCH %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_operand(input string name, input operand_t exp, input operand_t act);
      count_result(exp === act);
      if (exp !== act) begin
         $display("MISMATCH %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_opcode(input string name, input opcode_t exp, input opcode_t act);
      count_result(exp === act);
      if (exp !== act) begin
         $display("MISMATCH %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      count_result(exp === act);
      if (exp !== act) begin
         $display("MISMATCH %s expected %b actual %b", name, exp, act);
      end
   endtask

   // all inputs to a harmless idle value
   task automatic set_quiet();
      padv = 1'b1;
      flush = 1'b0;
      rfe = 1'b0;
      rf_wb = 1'b0;
      bf = 1'b0;
      bnf = 1'b0;
      pred = 1'b0;
      c_load = 1'b0;
      c_mfspr = 1'b0;
      ill = 1'b0;
      sys = 1'b0;
      flags = '0;
      opc = OPCODE_NOP;
      rfa = '0;
      rfb = '0;
      rfd = '0;
      c_rfd = '0;
      imm16 = '0;
      upper = '0;
      pc = 32'h0000_1000;
      dec_rfb = '0;
      ex_rfb = '0;
   endtask

   task automatic randomize_inputs();
      padv = (take_bits(3) != 32'd0);
      flush = (take_bits(5) == 32'd0);
      rfe = (take_bits(4) == 32'd0);
      rf_wb = take_bits(1) != 32'd0;
      flags = op_flags_t'(take_bits(14));
      opc = opcode_t'(take_bits(6));
      rfa = rf_adr_t'(take_bits(2));
      rfb = rf_adr_t'(take_bits(2));
      rfd = rf_adr_t'(take_bits(2));
      c_rfd = rf_adr_t'(take_bits(2));
      c_load = (take_bits(2) == 32'd0);
      c_mfspr = (take_bits(2) == 32'd0);
      imm16 = imm16_t'(take_bits(16));
      upper = immjbr_upper_t'(take_bits(10));
      pc = take_bits(32);
      dec_rfb = take_bits(32);
      ex_rfb = take_bits(32);
      bf = take_bits(1) != 32'd0;
      bnf = take_bits(1) != 32'd0;
      pred = take_bits(1) != 32'd0;
      ill = take_bits(1) != 32'd0;
      sys = take_bits(1) != 32'd0;
   endtask

   // decode outputs from the hazard and branch rules followed by the register update
   task automatic check_and_update();
      logic ctrl_il, late, bubble, imm_taken, branch, align;
      operand_t imm_target, target, next_pc, mp;
      ctrl_il = (c_load | c_mfspr) && (rfb == c_rfd);
      late = m_flags[OPF_LOAD] | m_flags[OPF_MFSPR];
      bubble = padv && ((late && (rfa == m_rfd || rfb == m_rfd)) ||
                        (flags[OPF_JR] && (ctrl_il || rfb == m_rfd)) || rfe);
      imm_taken = flags[OPF_JBR] && (opc[2:1] == 2'b00 || opc[2] == pred);
      imm_target = pc + {{4{upper[9]}}, upper, imm16, 2'b00};
      branch = (imm_taken || (flags[OPF_JR] && !ctrl_il)) && !flush && !bubble;
      if (imm_taken) begin
         target = imm_target;
      end else begin
         target = (m_bubble || m_flags[OPF_JR]) ? ex_rfb : dec_rfb;
      end
      align = branch && (target[1:0] != 2'b00);
      next_pc = pc + 32'd8;
      mp = ((bf && !pred) || (bnf && pred)) ? imm_target : next_pc;
      // execute state is unknown until the first reset edge
      if (!rst) begin
         check_bit("decode_bubble", bubble, d_bubble);
         check_bit("decode_branch", branch, d_branch);
         check_operand("branch_target", target, d_target);
      end
      if (rst || flush) begin
         m_flags = '0;
         m_rf_wb = 1'b0;
         m_opc = OPCODE_NOP;
         m_rfe = 1'b0;
         m_bubble = 1'b0;
      end else if (padv) begin
         m_bubble = bubble;
         m_rfe = rfe;
         m_flags = bubble ? '0 : flags;
         m_rf_wb = bubble ? 1'b0 : rf_wb;
         m_opc = bubble ? OPCODE_NOP : opc;
      end
      if (rst) begin
         m_ill = 1'b0;
         m_sys = 1'b0;
         m_align = 1'b0;
      end else if (padv) begin
         m_ill = ill;
         m_sys = sys;
         m_align = align;
      end
      m_valid = rst ? 1'b0 : padv;
      if (padv) begin
         m_rfd = rfd;
         m_imm16 = imm16;
         m_upper = upper;
         m_pc = pc;
         m_jal = next_pc;
         payload_known = 1'b1;
         if (flags[OPF_BRCOND]) begin
            m_mp = mp;
            m_pf = pred;
            mp_known = 1'b1;
         end
      end
   endtask

   task automatic check_registered();
      check_flags("execute_flags", m_flags, x_flags);
      check_bit("execute_rfe", m_rfe, x_rfe);
      check_bit("execute_rf_wb", m_rf_wb, x_rf_wb);
      check_opcode("execute_opcode", m_opc, x_opc);
      check_bit("execute_bubble", m_bubble, x_bubble);
      check_bit("decode_valid", m_valid, x_valid);
      check_bit("except_illegal", m_ill, x_ill);
      check_bit("except_syscall", m_sys, x_sys);
      check_bit("except_align", m_align, x_align);
      if (payload_known) begin
         check_operand("execute_rfd", operand_t'(m_rfd), operand_t'(x_rfd));
         check_operand("execute_imm16", operand_t'(m_imm16), operand_t'(x_imm16));
         check_operand("execute_upper", operand_t'(m_upper), operand_t'(x_upper));
         check_operand("pc_execute", m_pc, x_pc);
         check_operand("jal_result", m_jal, x_jal);
      end
      if (mp_known) begin
         check_operand("mispredict_target", m_mp, x_mp);
         check_bit("predicted_flag", m_pf, x_pf);
      end
   endtask

   // inputs were set right after a falling edge
   task automatic step_cycle();
      #10;
      check_and_update();
      @(negedge clk);
      check_registered();
   endtask

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count == TIMEOUT_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   initial begin
      rst = 1'b1;
      set_quiet();
      payload_known = 1'b0;
      mp_known = 1'b0;
      m_rfd = '0;
      m_flags = '0;
      m_bubble = 1'b0;
      for (int i = 0; i < RESET_CYCLES; i++) begin
         step_cycle();
      end
      rst = 1'b0;
      // load in decode followed by a load-use on rfa
      set_quiet();
      flags[OPF_LOAD] = 1'b1;
      rfd = 2'd1;
      step_cycle();
      set_quiet();
      rfa = 2'd1;
      rfb = 2'd2;
      rf_wb = 1'b1;
      opc = 6'h27;
      step_cycle();
      // stall holds everything
      set_quiet();
      padv = 1'b0;
      flags[OPF_ALU] = 1'b1;
      step_cycle();
      // flush wins over advance
      set_quiet();
      flush = 1'b1;
      flags[OPF_ADD] = 1'b1;
      rf_wb = 1'b1;
      step_cycle();
      set_quiet();
      rfe = 1'b1;
      step_cycle();
      // jal with a forward immediate target
      set_quiet();
      flags[OPF_JBR] = 1'b1;
      flags[OPF_JAL] = 1'b1;
      opc = 6'h01;
      pc = 32'h100;
      imm16 = 16'h3;
      step_cycle();
      // jr to a misaligned address
      set_quiet();
      flags[OPF_JR] = 1'b1;
      rfb = 2'd3;
      dec_rfb = 32'h203;
      step_cycle();
      // bf predicted not taken
      set_quiet();
      flags[OPF_JBR] = 1'b1;
      flags[OPF_BRCOND] = 1'b1;
      bf = 1'b1;
      opc = 6'h04;
      imm16 = 16'hFFF0;
      upper = 10'h3FF;
      step_cycle();
      for (int i = 0; i < RANDOM_CYCLES; i++) begin
         randomize_inputs();
         step_cycle();
      end
      $display("checks: %0d errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule
